/* design/kudu_cfg.svh */
//////////////////////////////////////////////////////////////////////
// Execute cluster configuration
// Register file geometry shared by packages and RTL
//////////////////////////////////////////////////////////////////////

`ifndef KUDU_CFG_SVH
`define KUDU_CFG_SVH

// Integer data width
`define KUDU_REG_W 32

// Architectural register count, x0 included
`define KUDU_NREGS 32

// Register address width
`define KUDU_RADDR_W 5

`endif

/* design/isa_pkg.sv */
//////////////////////////////////////////////////////////////////////
// RV32I integer instruction formats and ALU operation codes
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "kudu_cfg.svh"

package isa_pkg;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  // Register-register layout
  typedef struct packed {
    logic [6:0]               funct7;
    logic [`KUDU_RADDR_W-1:0] rs2;
    logic [`KUDU_RADDR_W-1:0] rs1;
    logic [2:0]               funct3;
    logic [`KUDU_RADDR_W-1:0] rd;
    logic [6:0]               opcode;
  } r_fmt_t;

  // Register-immediate layout
  typedef struct packed {
    logic [11:0]              imm12;
    logic [`KUDU_RADDR_W-1:0] rs1;
    logic [2:0]               funct3;
    logic [`KUDU_RADDR_W-1:0] rd;
    logic [6:0]               opcode;
  } i_fmt_t;

  // Opcode picks which view is meaningful
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } instr_word_u;

  typedef enum logic [3:0] {
    ALU_NONE = 4'd0,
    ALU_ADD  = 4'd1,
    ALU_SUB  = 4'd2,
    ALU_AND  = 4'd3,
    ALU_OR   = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SLL  = 4'd6,
    ALU_SRL  = 4'd7,
    ALU_SRA  = 4'd8,
    ALU_SLT  = 4'd9,
    ALU_SLTU = 4'd10
  } alu_op_e;

endpackage

`default_nettype wire

/* design/pipe_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Types between the ALU pipelines, committer and register file
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "kudu_cfg.svh"

package pipe_pkg;

  typedef struct packed {
    logic                  valid;
    isa_pkg::instr_word_u  instr;
  } issue_slot_t;

  typedef struct packed {
    logic [`KUDU_RADDR_W-1:0] rs1;
    logic [`KUDU_RADDR_W-1:0] rs2;
  } rf_raddr_t;

  typedef struct packed {
    logic [`KUDU_REG_W-1:0] rs1_data;
    logic [`KUDU_REG_W-1:0] rs2_data;
  } rf_rdata_t;

  // Registered result of one pipeline
  typedef struct packed {
    logic                     valid;
    logic                     we;
    logic [`KUDU_RADDR_W-1:0] rd;
    logic [`KUDU_REG_W-1:0]   result;
  } pl_out_t;

  typedef struct packed {
    logic                     we;
    logic                     valid;
    logic [`KUDU_RADDR_W-1:0] addr;
    logic [`KUDU_REG_W-1:0]   data;
  } rf_wr_t;

  // Index 0 is the older slot
  typedef rf_wr_t [1:0] cmt_wr_t;

endpackage

`default_nettype wire

/* design/regfile.sv */
//////////////////////////////////////////////////////////////////////
// Integer register file, four reads and two writes per cycle
// Reads are combinational and x0 is hardwired to zero
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "kudu_cfg.svh"

module regfile (
  input  logic                clk_i,
  input  logic                reset_i,
  input  pipe_pkg::rf_raddr_t raddr0_i,
  input  pipe_pkg::rf_raddr_t raddr1_i,
  output pipe_pkg::rf_rdata_t rdata0_o,
  output pipe_pkg::rf_rdata_t rdata1_o,
  input  pipe_pkg::cmt_wr_t   wr_i
);

  logic [`KUDU_REG_W-1:0] regs [1:`KUDU_NREGS-1];

  function automatic logic [`KUDU_REG_W-1:0] rd_reg(input logic [`KUDU_RADDR_W-1:0] addr);
    return (addr == '0) ? '0 : regs[addr];
  endfunction

  // Port 1 is the younger slot, so it is applied last
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 1; i < `KUDU_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int i = 1; i < `KUDU_NREGS; i++) begin
        if (wr_i[1].we && (wr_i[1].addr == i[`KUDU_RADDR_W-1:0])) begin
          regs[i] <= wr_i[1].data;
        end else if (wr_i[0].we && (wr_i[0].addr == i[`KUDU_RADDR_W-1:0])) begin
          regs[i] <= wr_i[0].data;
        end
      end
    end
  end

  assign rdata0_o.rs1_data = rd_reg(raddr0_i.rs1);
  assign rdata0_o.rs2_data = rd_reg(raddr0_i.rs2);
  assign rdata1_o.rs1_data = rd_reg(raddr1_i.rs1);
  assign rdata1_o.rs2_data = rd_reg(raddr1_i.rs2);

endmodule

`default_nettype wire

/* design/alu_pipeline.sv */
//////////////////////////////////////////////////////////////////////
// Single issue slot ALU pipeline
// Decode, operand forwarding, ALU and one output register stage
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "kudu_cfg.svh"

module alu_pipeline (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  flush_i,
  input  pipe_pkg::issue_slot_t slot_i,
  input  logic                  ds_rdy_i,
  output pipe_pkg::rf_raddr_t   raddr_o,
  input  pipe_pkg::rf_rdata_t   rdata_i,
  input  pipe_pkg::cmt_wr_t     fwd_i,
  output pipe_pkg::pl_out_t     pl_out_o
);

  localparam int SHAMT_W = $clog2(`KUDU_REG_W);

  isa_pkg::instr_word_u     instr;
  isa_pkg::alu_op_e         alu_op;
  logic                     is_op;
  logic                     is_op_imm;
  logic [2:0]               funct3;
  logic                     alt;
  logic [`KUDU_REG_W-1:0]   imm_sext;
  logic [`KUDU_REG_W-1:0]   op_a;
  logic [`KUDU_REG_W-1:0]   src2;
  logic [`KUDU_REG_W-1:0]   op_b;
  logic [SHAMT_W-1:0]       shamt;
  logic [`KUDU_REG_W-1:0]   result;

  logic                     valid_q;
  logic                     we_q;
  logic [`KUDU_RADDR_W-1:0] rd_q;
  logic [`KUDU_REG_W-1:0]   result_q;

  // Later committed write takes precedence
  function automatic logic [`KUDU_REG_W-1:0] fwd_sel(
    input logic [`KUDU_RADDR_W-1:0] addr,
    input logic [`KUDU_REG_W-1:0]   rf_val,
    input pipe_pkg::cmt_wr_t        fwd
  );
    logic [`KUDU_REG_W-1:0] val;
    val = rf_val;
    if (addr != '0) begin
      if (fwd[1].we && (fwd[1].addr == addr)) begin
        val = fwd[1].data;
      end else if (fwd[0].we && (fwd[0].addr == addr)) begin
        val = fwd[0].data;
      end
    end
    return val;
  endfunction

  assign instr     = slot_i.instr;
  assign is_op     = (instr.r.opcode == isa_pkg::OPC_OP);
  assign is_op_imm = (instr.i.opcode == isa_pkg::OPC_OP_IMM);
  assign funct3    = instr.i.funct3;

  // funct7[5] and imm[10] share the SUB and SRA select bit
  assign alt       = instr.r.funct7[5];
  assign imm_sext  = {{(`KUDU_REG_W-12){instr.i.imm12[11]}}, instr.i.imm12};

  always_comb begin
    alu_op = isa_pkg::ALU_NONE;
    if (is_op || is_op_imm) begin
      case (funct3)
        3'b000:  alu_op = (is_op && alt) ? isa_pkg::ALU_SUB : isa_pkg::ALU_ADD;
        3'b001:  alu_op = isa_pkg::ALU_SLL;
        3'b010:  alu_op = isa_pkg::ALU_SLT;
        3'b011:  alu_op = isa_pkg::ALU_SLTU;
        3'b100:  alu_op = isa_pkg::ALU_XOR;
        3'b101:  alu_op = alt ? isa_pkg::ALU_SRA : isa_pkg::ALU_SRL;
        3'b110:  alu_op = isa_pkg::ALU_OR;
        default: alu_op = isa_pkg::ALU_AND;
      endcase
    end
  end

  assign raddr_o.rs1 = instr.r.rs1;
  assign raddr_o.rs2 = instr.r.rs2;

  assign op_a  = fwd_sel(instr.r.rs1, rdata_i.rs1_data, fwd_i);
  assign src2  = fwd_sel(instr.r.rs2, rdata_i.rs2_data, fwd_i);
  assign op_b  = is_op_imm ? imm_sext : src2;
  assign shamt = op_b[SHAMT_W-1:0];

  always_comb begin
    case (alu_op)
      isa_pkg::ALU_ADD:  result = op_a + op_b;
      isa_pkg::ALU_SUB:  result = op_a - op_b;
      isa_pkg::ALU_AND:  result = op_a & op_b;
      isa_pkg::ALU_OR:   result = op_a | op_b;
      isa_pkg::ALU_XOR:  result = op_a ^ op_b;
      isa_pkg::ALU_SLL:  result = op_a << shamt;
      isa_pkg::ALU_SRL:  result = op_a >> shamt;
      isa_pkg::ALU_SRA:  result = $signed(op_a) >>> shamt;
      isa_pkg::ALU_SLT:  result = {{(`KUDU_REG_W-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      isa_pkg::ALU_SLTU: result = {{(`KUDU_REG_W-1){1'b0}}, op_a < op_b};
      default:           result = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      valid_q <= 1'b0;
      we_q    <= 1'b0;
    end else if (ds_rdy_i) begin
      valid_q <= slot_i.valid;
      we_q    <= slot_i.valid && (alu_op != isa_pkg::ALU_NONE) && (instr.r.rd != '0);
    end
  end

  always_ff @(posedge clk_i) begin
    if (ds_rdy_i && slot_i.valid) begin
      rd_q     <= instr.r.rd;
      result_q <= result;
    end
  end

  assign pl_out_o.valid  = valid_q;
  assign pl_out_o.we     = we_q;
  assign pl_out_o.rd     = rd_q;
  assign pl_out_o.result = result_q;

endmodule

`default_nettype wire

/* design/committer.sv */
//////////////////////////////////////////////////////////////////////
// Result committer for the two ALU pipelines
// Orders the writes, resolves same-rd pairs and applies hold
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module committer (
  input  logic              hold_i,
  input  pipe_pkg::pl_out_t pl0_i,
  input  pipe_pkg::pl_out_t pl1_i,
  output logic              pl_rdy_o,
  output pipe_pkg::cmt_wr_t cmt_wr_o
);

  logic cmt0;
  logic cmt1;
  logic waw_drop;

  // Results leave the pipelines only when not held
  assign pl_rdy_o = ~hold_i;

  assign cmt0 = pl0_i.valid && pl_rdy_o;
  assign cmt1 = pl1_i.valid && pl_rdy_o;

  // Younger slot overwrites the same rd
  assign waw_drop = pl1_i.valid && pl1_i.we && (pl1_i.rd == pl0_i.rd);

  always_comb begin
    cmt_wr_o[0].valid = cmt0;
    cmt_wr_o[0].we    = cmt0 && pl0_i.we && !waw_drop;
    cmt_wr_o[0].addr  = pl0_i.rd;
    cmt_wr_o[0].data  = pl0_i.result;

    cmt_wr_o[1].valid = cmt1;
    cmt_wr_o[1].we    = cmt1 && pl1_i.we;
    cmt_wr_o[1].addr  = pl1_i.rd;
    cmt_wr_o[1].data  = pl1_i.result;
  end

endmodule

`default_nettype wire

/* design/kudu_exec_top.sv */
//////////////////////////////////////////////////////////////////////
// Dual-issue integer execute cluster
// Register file, two ALU pipelines and the committer
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module kudu_exec_top (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  pipe_pkg::issue_slot_t [1:0] issue_i,
  input  logic                        hold_i,
  input  logic                        flush_i,
  output logic                        issue_rdy_o,
  output pipe_pkg::cmt_wr_t           cmt_wr_o
);

  pipe_pkg::rf_raddr_t rf_raddr0;
  pipe_pkg::rf_raddr_t rf_raddr1;
  pipe_pkg::rf_rdata_t rf_rdata0;
  pipe_pkg::rf_rdata_t rf_rdata1;
  pipe_pkg::pl_out_t   pl0_out;
  pipe_pkg::pl_out_t   pl1_out;
  pipe_pkg::cmt_wr_t   cmt_wr;
  logic                pl_rdy;

  assign issue_rdy_o = pl_rdy;
  assign cmt_wr_o    = cmt_wr;

  regfile regfile_inst (
    .clk_i    (clk_i    ),
    .reset_i  (reset_i  ),
    .raddr0_i (rf_raddr0),
    .raddr1_i (rf_raddr1),
    .rdata0_o (rf_rdata0),
    .rdata1_o (rf_rdata1),
    .wr_i     (cmt_wr   )
  );

  // Slot 0, older instruction of the pair
  alu_pipeline alu_pipeline0_inst (
    .clk_i    (clk_i     ),
    .reset_i  (reset_i   ),
    .flush_i  (flush_i   ),
    .slot_i   (issue_i[0]),
    .ds_rdy_i (pl_rdy    ),
    .raddr_o  (rf_raddr0 ),
    .rdata_i  (rf_rdata0 ),
    .fwd_i    (cmt_wr    ),
    .pl_out_o (pl0_out   )
  );

  // Slot 1, younger instruction of the pair
  alu_pipeline alu_pipeline1_inst (
    .clk_i    (clk_i     ),
    .reset_i  (reset_i   ),
    .flush_i  (flush_i   ),
    .slot_i   (issue_i[1]),
    .ds_rdy_i (pl_rdy    ),
    .raddr_o  (rf_raddr1 ),
    .rdata_i  (rf_rdata1 ),
    .fwd_i    (cmt_wr    ),
    .pl_out_o (pl1_out   )
  );

  committer committer_inst (
    .hold_i   (hold_i ),
    .pl0_i    (pl0_out),
    .pl1_i    (pl1_out),
    .pl_rdy_o (pl_rdy ),
    .cmt_wr_o (cmt_wr )
  );

endmodule

`default_nettype wire

/* bench/kudu_exec_tb.sv */
//////////////////////////////////////////////////////////////////////
// Directed testbench for the dual-issue execute cluster
// Reference register model, pair driver and commit checks
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module kudu_exec_tb;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 16;
  localparam int LOAD_PAIRS   = 16;
  localparam int RAND_PAIRS   = 40;
  localparam int MISC_CYCLES  = 80;
  localparam int TOTAL_CYCLES = RESET_CYCLES + 2 * (LOAD_PAIRS + RAND_PAIRS) + MISC_CYCLES;
  localparam logic [6:0] OPC_R = 7'h33;
  localparam logic [6:0] OPC_I = 7'h13;

  logic                        clk_i;
  logic                        reset_i;
  pipe_pkg::issue_slot_t [1:0] issue_i;
  logic                        hold_i;
  logic                        flush_i;
  logic                        issue_rdy_o;
  pipe_pkg::cmt_wr_t           cmt_wr_o;

  logic [31:0]       ref_regs [0:31];
  logic [31:0]       seq_q [$];
  pipe_pkg::cmt_wr_t exp_wr;
  int                err_cnt;

  kudu_exec_top kudu_exec_top_inst (
    .clk_i       (clk_i      ),
    .reset_i     (reset_i    ),
    .issue_i     (issue_i    ),
    .hold_i      (hold_i     ),
    .flush_i     (flush_i    ),
    .issue_rdy_o (issue_rdy_o),
    .cmt_wr_o    (cmt_wr_o   )
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #(TOTAL_CYCLES * CLK_PERIOD * 4);
    $display("watchdog expired before the tests finished");
    $display("test failed");
    $finish;
  end

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_R};
  endfunction

  function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [11:0] imm,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {imm, rs1, f3, rd, opc};
  endfunction

  // Slot 1 sits in the upper half
  function automatic logic [65:0] make_pair(input logic [31:0] w0, input logic [31:0] w1);
    return {1'b1, w1, 1'b1, w0};
  endfunction

  function automatic logic [4:0] rand_reg();
    logic [31:0] r;
    r = $urandom;
    return r[4:0];
  endfunction

  // RV32I semantics for one word against the model state
  task automatic model_exec(input logic [31:0] w, output logic we, output logic [4:0] rd,
                            output logic [31:0] res);
    logic [31:0] a;
    logic [31:0] b;
    logic        is_r;
    logic        is_i;
    is_r = (w[6:0] == OPC_R);
    is_i = (w[6:0] == OPC_I);
    rd   = w[11:7];
    a    = ref_regs[w[19:15]];
    b    = is_r ? ref_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
    case (w[14:12])
      3'd0:    res = (is_r && w[30]) ? a - b : a + b;
      3'd1:    res = a << b[4:0];
      3'd2:    res = {31'b0, $signed(a) < $signed(b)};
      3'd3:    res = {31'b0, a < b};
      3'd4:    res = a ^ b;
      3'd5:    res = w[30] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    res = a | b;
      default: res = a & b;
    endcase
    we = (is_r || is_i) && (rd != 5'd0);
  endtask

  // Both slots read first, then port 0 and port 1 write in order
  task automatic predict_pair(input logic [31:0] w0, input logic [31:0] w1);
    logic        we0;
    logic        we1;
    logic [4:0]  d0;
    logic [4:0]  d1;
    logic [31:0] r0;
    logic [31:0] r1;
    model_exec(w0, we0, d0, r0);
    model_exec(w1, we1, d1, r1);
    exp_wr[0].valid = 1'b1;
    exp_wr[0].we    = we0 && !(we1 && (d1 == d0));
    exp_wr[0].addr  = d0;
    exp_wr[0].data  = r0;
    exp_wr[1].valid = 1'b1;
    exp_wr[1].we    = we1;
    exp_wr[1].addr  = d1;
    exp_wr[1].data  = r1;
    if (we0) ref_regs[d0] = r0;
    if (we1) ref_regs[d1] = r1;
  endtask

  task automatic report_value(input string sig, input logic [31:0] exp, input logic [31:0] got);
    err_cnt++;
    $display("FAILED %s expected %h got %h at %0t", sig, exp, got, $time);
  endtask

  task automatic check_commit();
    for (int p = 0; p < 2; p++) begin
      if (cmt_wr_o[p].valid !== exp_wr[p].valid) begin
        report_value($sformatf("cmt_wr_o[%0d].valid", p), {31'b0, exp_wr[p].valid},
                     {31'b0, cmt_wr_o[p].valid});
      end
      if (cmt_wr_o[p].we !== exp_wr[p].we) begin
        report_value($sformatf("cmt_wr_o[%0d].we", p), {31'b0, exp_wr[p].we},
                     {31'b0, cmt_wr_o[p].we});
      end else if (exp_wr[p].we) begin
        if (cmt_wr_o[p].addr !== exp_wr[p].addr) begin
          report_value($sformatf("cmt_wr_o[%0d].addr", p), {27'b0, exp_wr[p].addr},
                       {27'b0, cmt_wr_o[p].addr});
        end
        if (cmt_wr_o[p].data !== exp_wr[p].data) begin
          report_value($sformatf("cmt_wr_o[%0d].data", p), exp_wr[p].data, cmt_wr_o[p].data);
        end
      end
    end
  endtask

  task automatic check_no_write();
    for (int p = 0; p < 2; p++) begin
      if (cmt_wr_o[p].we !== 1'b0) begin
        report_value($sformatf("cmt_wr_o[%0d].we", p), 32'h0, {31'b0, cmt_wr_o[p].we});
      end
    end
  endtask

  // Issues the queued pairs back to back, one check per pair
  task automatic run_queued_pairs();
    logic [31:0] w0;
    logic [31:0] w1;
    logic        more;
    @(posedge clk_i);
    w0 = seq_q.pop_front();
    w1 = seq_q.pop_front();
    issue_i <= make_pair(w0, w1);
    more = 1'b1;
    while (more) begin
      predict_pair(w0, w1);
      @(posedge clk_i);
      if (seq_q.size() >= 2) begin
        w0 = seq_q.pop_front();
        w1 = seq_q.pop_front();
        issue_i <= make_pair(w0, w1);
      end else begin
        issue_i <= '0;
        more = 1'b0;
      end
      @(negedge clk_i);
      check_commit();
    end
  endtask

  task automatic reset_idle_check();
    repeat (3) begin
      @(negedge clk_i);
      check_no_write();
      if (issue_rdy_o !== 1'b1) begin
        report_value("issue_rdy_o", 32'h1, {31'b0, issue_rdy_o});
      end
    end
  endtask

  task automatic random_reg_ops();
    logic [31:0] r;
    logic [6:0]  f7 [0:9];
    logic [2:0]  f3 [0:9];
    f7 = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h20, 7'h00, 7'h00};
    f3 = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    for (int i = 1; i < 32; i += 2) begin
      r = $urandom;
      seq_q.push_back(enc_i(OPC_I, r[11:0], 5'd0, 3'd0, i[4:0]));
      seq_q.push_back(enc_i(OPC_I, r[27:16], 5'd0, 3'd0, i[4:0] + 5'd1));
    end
    run_queued_pairs();
    for (int k = 0; k < RAND_PAIRS; k++) begin
      seq_q.push_back(enc_r(f7[k % 10], rand_reg(), rand_reg(), f3[k % 10], rand_reg()));
      seq_q.push_back(enc_r(f7[(k + 3) % 10], rand_reg(), rand_reg(), f3[(k + 3) % 10],
                            rand_reg()));
    end
    run_queued_pairs();
  endtask

  task automatic immediate_ops();
    seq_q.push_back(enc_i(OPC_I, 12'hfff, 5'd1, 3'd0, 5'd17));
    seq_q.push_back(enc_i(OPC_I, 12'h800, 5'd0, 3'd0, 5'd18));
    seq_q.push_back(enc_i(OPC_I, 12'h7ff, 5'd2, 3'd0, 5'd19));
    seq_q.push_back(enc_i(OPC_I, 12'hffb, 5'd3, 3'd2, 5'd20));
    seq_q.push_back(enc_i(OPC_I, 12'hfff, 5'd4, 3'd3, 5'd21));
    seq_q.push_back(enc_i(OPC_I, 12'h9a5, 5'd5, 3'd4, 5'd22));
    seq_q.push_back(enc_i(OPC_I, 12'hf0f, 5'd6, 3'd6, 5'd23));
    seq_q.push_back(enc_i(OPC_I, 12'h8ff, 5'd7, 3'd7, 5'd24));
    seq_q.push_back(enc_i(OPC_I, 12'h00d, 5'd8, 3'd1, 5'd25));
    seq_q.push_back(enc_i(OPC_I, 12'h007, 5'd9, 3'd5, 5'd26));
    seq_q.push_back(enc_i(OPC_I, 12'h409, 5'd10, 3'd5, 5'd27));
    // Load opcode, outside the supported set
    seq_q.push_back(enc_i(7'h03, 12'h004, 5'd1, 3'd2, 5'd28));
    seq_q.push_back(enc_i(OPC_I, 12'h321, 5'd11, 3'd0, 5'd29));
    seq_q.push_back(enc_i(7'h63, 12'h010, 5'd2, 3'd0, 5'd30));
    run_queued_pairs();
  endtask

  task automatic forwarding_chain();
    seq_q.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd5));
    seq_q.push_back(enc_r(7'h00, 5'd4, 5'd3, 3'd4, 5'd6));
    seq_q.push_back(enc_r(7'h20, 5'd6, 5'd5, 3'd0, 5'd7));
    seq_q.push_back(enc_r(7'h00, 5'd5, 5'd6, 3'd1, 5'd8));
    seq_q.push_back(enc_r(7'h00, 5'd8, 5'd7, 3'd3, 5'd9));
    seq_q.push_back(enc_r(7'h00, 5'd8, 5'd7, 3'd0, 5'd10));
    // Slot 1 must see the old x11
    seq_q.push_back(enc_i(OPC_I, 12'h064, 5'd0, 3'd0, 5'd11));
    seq_q.push_back(enc_r(7'h00, 5'd11, 5'd11, 3'd0, 5'd12));
    run_queued_pairs();
  endtask

  task automatic same_rd_and_x0();
    seq_q.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd13));
    seq_q.push_back(enc_r(7'h20, 5'd4, 5'd3, 3'd0, 5'd13));
    seq_q.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd0));
    seq_q.push_back(enc_r(7'h00, 5'd0, 5'd5, 3'd6, 5'd14));
    seq_q.push_back(enc_i(OPC_I, 12'h001, 5'd0, 3'd0, 5'd0));
    seq_q.push_back(enc_r(7'h20, 5'd0, 5'd5, 3'd0, 5'd15));
    seq_q.push_back(enc_r(7'h00, 5'd0, 5'd13, 3'd6, 5'd16));
    seq_q.push_back(enc_r(7'h00, 5'd13, 5'd0, 3'd0, 5'd17));
    run_queued_pairs();
  endtask

  task automatic hold_and_flush();
    logic [31:0] w0;
    logic [31:0] w1;
    w0 = enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd15);
    w1 = enc_r(7'h00, 5'd4, 5'd3, 3'd7, 5'd16);
    @(posedge clk_i);
    issue_i <= make_pair(w0, w1);
    predict_pair(w0, w1);
    @(posedge clk_i);
    issue_i <= '0;
    hold_i  <= 1'b1;
    repeat (3) begin
      @(negedge clk_i);
      check_no_write();
      if (issue_rdy_o !== 1'b0) begin
        report_value("issue_rdy_o", 32'h0, {31'b0, issue_rdy_o});
      end
      @(posedge clk_i);
    end
    hold_i <= 1'b0;
    @(negedge clk_i);
    check_commit();

    // In-flight pair is held back and then flushed
    @(posedge clk_i);
    issue_i <= make_pair(enc_i(OPC_I, 12'h123, 5'd20, 3'd0, 5'd20),
                         enc_i(OPC_I, 12'h456, 5'd21, 3'd0, 5'd21));
    @(posedge clk_i);
    issue_i <= '0;
    hold_i  <= 1'b1;
    flush_i <= 1'b1;
    @(negedge clk_i);
    check_no_write();
    @(posedge clk_i);
    hold_i  <= 1'b0;
    flush_i <= 1'b0;
    @(negedge clk_i);
    check_no_write();

    // Pair presented during a flush
    @(posedge clk_i);
    issue_i <= make_pair(enc_i(OPC_I, 12'h0f0, 5'd22, 3'd4, 5'd22),
                         enc_i(OPC_I, 12'h00f, 5'd23, 3'd6, 5'd23));
    flush_i <= 1'b1;
    @(posedge clk_i);
    issue_i <= '0;
    flush_i <= 1'b0;
    @(negedge clk_i);
    check_no_write();

    seq_q.push_back(enc_r(7'h00, 5'd0, 5'd20, 3'd6, 5'd24));
    seq_q.push_back(enc_r(7'h00, 5'd0, 5'd21, 3'd6, 5'd25));
    seq_q.push_back(enc_r(7'h00, 5'd0, 5'd22, 3'd6, 5'd26));
    seq_q.push_back(enc_r(7'h00, 5'd0, 5'd23, 3'd6, 5'd27));
    seq_q.push_back(enc_r(7'h00, 5'd16, 5'd15, 3'd0, 5'd28));
    seq_q.push_back(enc_r(7'h00, 5'd0, 5'd15, 3'd6, 5'd29));
    run_queued_pairs();
  endtask

  initial begin
    reset_i = 1'b1;
    issue_i = '0;
    hold_i  = 1'b0;
    flush_i = 1'b0;
    err_cnt = 0;
    void'($urandom(32'h7bce_319e));
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = 32'h0;
    end
    repeat (RESET_CYCLES) @(posedge clk_i);
    reset_i <= 1'b0;

    reset_idle_check();
    random_reg_ops();
    immediate_ops();
    forwarding_chain();
    same_rd_and_x0();
    hold_and_flush();

    @(posedge clk_i);
    $display("errors: %0d", err_cnt);
    if (err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+design
design/isa_pkg.sv
design/pipe_pkg.sv
design/regfile.sv
design/alu_pipeline.sv
design/committer.sv
design/kudu_exec_top.sv
bench/kudu_exec_tb.sv

/* Makefile */
# Verilator build and run for the execute cluster testbench

TOP := kudu_exec_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f src.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
